/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ns
TOP       = tb_mem_subsystem
FLIST     = flist.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
SOURCES   = $(shell grep '\.sv$$' $(FLIST)) $(wildcard include/*.svh)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# Status comes from the search for the pass line
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)

/* flist.f */
+incdir+include
verilog/mem_pkg.sv
verilog/mem_stage_ifs.sv
verilog/ex_mem_latch.sv
verilog/byte_bank.sv
verilog/mem_access_stage.sv
verilog/writeback_stage.sv
verilog/mem_subsystem_top.sv
sim/tb_mem_subsystem.sv

/* include/mem_macros.svh */
`ifndef MEM_MACROS_SVH
`define MEM_MACROS_SVH

// Data and address width
`define MEM_XLEN 32

// Byte banks making up one data word
`define MEM_LANES 4

// Word address width of each bank for 1024 entries
`define MEM_BANK_AWIDTH 10

// Lowest byte address bit used as bank address
`define MEM_BANK_ALO 2

`endif

/* sim/tb_mem_subsystem.sv */
`timescale 1ns/1ns

module tb_mem_subsystem import mem_pkg::*; ();

    localparam int NUM_RANDOM = 400;
    // Random part plus about 150 directed, reset and drain cycles
    localparam int TIMEOUT_NS = (NUM_RANDOM + 200) * 4;

    // Operation bits are {valid, load, store, jal, lui}
    localparam logic [4:0] OP_IDLE  = 5'b00000;
    localparam logic [4:0] OP_ALU   = 5'b10000;
    localparam logic [4:0] OP_LUI   = 5'b10001;
    localparam logic [4:0] OP_JAL   = 5'b10010;
    localparam logic [4:0] OP_STORE = 5'b10100;
    localparam logic [4:0] OP_LOAD  = 5'b11000;

    logic        clk;
    logic        reset;
    logic        valid;
    logic        mem_read;
    logic        mem_write;
    logic        jal;
    logic        lui;
    mem_mask_t   mem_type;
    logic [31:0] alu_out;
    logic [31:0] store_data;
    logic [31:0] imm;
    logic [31:0] pc_inc;
    logic        wb_forward;
    logic [4:0]  rd;
    logic        wb_valid;
    logic [4:0]  wb_rd;
    logic [31:0] wb_result;

    // Byte image of the 64-byte window the tests use
    logic [7:0]  ref_mem [64];
    logic        exp_valid_q [$];
    logic [4:0]  exp_rd_q [$];
    logic [31:0] exp_data_q [$];
    logic [31:0] lfsr;
    logic [31:0] last_result;
    logic        last_valid;
    int          errors;
    int          checks;

    mem_subsystem_top i_mem_subsystem_top (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic void model_store(input mem_mask_t t, input logic [5:0] a,
                                        input logic [31:0] d);
        case (t)
            MEM_BYTE: ref_mem[a] = d[7:0];
            MEM_HALF: begin
                ref_mem[{a[5:1], 1'b0}] = d[7:0];
                ref_mem[{a[5:1], 1'b1}] = d[15:8];
            end
            MEM_WORD: begin
                for (int i = 0; i < 4; i++) begin
                    ref_mem[{a[5:2], 2'(i)}] = d[8*i +: 8];
                end
            end
            // Unsigned types are loads only and leave memory alone
            default: ;
        endcase
    endfunction

    function automatic logic [31:0] model_load(input mem_mask_t t, input logic [5:0] a);
        logic [31:0] w;
        logic [7:0]  b;
        logic [15:0] h;
        for (int i = 0; i < 4; i++) begin
            w[8*i +: 8] = ref_mem[{a[5:2], 2'(i)}];
        end
        b = w[{a[1:0], 3'b000} +: 8];
        h = a[1] ? w[31:16] : w[15:0];
        case (t)
            MEM_BYTE:  return {{24{b[7]}}, b};
            MEM_UBYTE: return {24'd0, b};
            MEM_HALF:  return {{16{h[15]}}, h};
            MEM_UHALF: return {16'd0, h};
            default:   return w;
        endcase
    endfunction

    // One instruction per clock with its expected result queued in issue order
    task automatic issue(input logic [4:0] op, input mem_mask_t t, input logic [31:0] alu,
                         input logic [31:0] sd, input logic fwd);
        logic [31:0] imm_v;
        logic [31:0] pc_v;
        logic [31:0] r;
        logic [31:0] res;
        imm_v = rand_bits(20) << 12;
        pc_v  = rand_bits(30) << 2;
        r     = rand_bits(5);
        if (op[2]) begin
            model_store(t, alu[5:0], fwd ? last_result : sd);
        end
        res = op[3] ? model_load(t, alu[5:0]) : (op[1] ? pc_v : (op[0] ? imm_v : alu));
        @(posedge clk);
        {valid, mem_read, mem_write, jal, lui} <= op;
        mem_type   <= t;
        alu_out    <= alu;
        store_data <= sd;
        imm        <= imm_v;
        pc_inc     <= pc_v;
        wb_forward <= fwd;
        rd         <= r[4:0];
        exp_valid_q.push_back(op[4]);
        exp_rd_q.push_back(r[4:0]);
        exp_data_q.push_back(res);
        last_result = res;
        last_valid  = op[4];
    endtask

    // Result of the slot driven two edges back is stable here
    always @(negedge clk) begin : compare_output
        logic        ev;
        logic [4:0]  er;
        logic [31:0] ed;
        if (exp_valid_q.size() >= 3) begin
            ev = exp_valid_q.pop_front();
            er = exp_rd_q.pop_front();
            ed = exp_data_q.pop_front();
            checks++;
            assert (wb_valid === ev && (!ev || (wb_rd === er && wb_result === ed))) else begin
                errors++;
                $display("mismatch at %0t: expected valid %b rd %0d data %h, got %b %0d %h",
                         $time, ev, er, ed, wb_valid, wb_rd, wb_result);
            end
        end else if ($time > 0) begin
            // During reset and until the first issued slot comes out
            assert (wb_valid === 1'b0) else begin
                errors++;
                $display("mismatch at %0t: wb_valid set before the first result was due",
                         $time);
            end
        end
    end

    initial begin : stimulus
        logic [31:0] r;
        logic [31:0] alu;
        logic [5:0]  addr6;
        mem_mask_t   t;
        errors      = 0;
        checks      = 0;
        lfsr        = 32'h26a8d392;
        last_result = '0;
        last_valid  = 1'b0;
        addr6       = '0;
        reset       = 1'b1;
        {valid, mem_read, mem_write, jal, lui, wb_forward} = '0;
        mem_type    = MEM_WORD;
        {alu_out, store_data, imm, pc_inc} = '0;
        rd          = '0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        repeat (3) issue(OP_IDLE, MEM_WORD, '0, '0, 1'b0);

        for (int i = 0; i < 64; i += 4) begin
            issue(OP_STORE, MEM_WORD, i, rand_bits(32), 1'b0);
        end
        issue(OP_STORE, MEM_WORD, 32'd0, 32'hf0e1_7e02, 1'b0);
        // Every load type at every offset through addresses with high bits set
        for (int i = 0; i < 16; i++) begin
            issue(OP_LOAD, MEM_BYTE, 32'h5a5a_5000 + i, '0, 1'b0);
            issue(OP_LOAD, MEM_UBYTE, 32'h5a5a_5000 + i, '0, 1'b0);
            issue(OP_LOAD, MEM_HALF, 32'h5a5a_5000 + i, '0, 1'b0);
            issue(OP_LOAD, MEM_UHALF, 32'h5a5a_5000 + i, '0, 1'b0);
            issue(OP_LOAD, MEM_WORD, 32'h5a5a_5000 + i, '0, 1'b0);
        end
        for (int i = 0; i < 4; i++) begin
            issue(OP_STORE, MEM_BYTE, 32'd16 + i, 32'h0000_0080 + i, 1'b0);
            issue(OP_LOAD, MEM_WORD, 32'd16, '0, 1'b0);
            issue(OP_STORE, MEM_HALF, 32'd20 + i, 32'h0000_9000 + i, 1'b0);
            issue(OP_LOAD, MEM_WORD, 32'd20, '0, 1'b0);
            issue(OP_STORE, MEM_UBYTE, 32'd24 + i, 32'hffff_ffff, 1'b0);
            issue(OP_STORE, MEM_UHALF, 32'd24 + i, 32'hffff_ffff, 1'b0);
            issue(OP_LOAD, MEM_WORD, 32'd24, '0, 1'b0);
        end

        issue(OP_JAL, MEM_WORD, 32'h1357_9bdf, '0, 1'b0);
        issue(OP_LUI, MEM_WORD, 32'h1357_9bdf, '0, 1'b0);
        issue(OP_JAL | OP_LUI, MEM_WORD, 32'h1357_9bdf, '0, 1'b0);
        issue(OP_ALU, MEM_WORD, 32'h1357_9bdf, '0, 1'b0);

        // Forwarded stores after a register result and after a load
        issue(OP_ALU, MEM_WORD, 32'hc0de_0018, '0, 1'b0);
        issue(OP_STORE, MEM_WORD, 32'd32, 32'hdead_beef, 1'b1);
        issue(OP_LOAD, MEM_HALF, 32'd2, '0, 1'b0);
        issue(OP_STORE, MEM_BYTE, 32'd37, 32'hdead_beef, 1'b1);
        issue(OP_LOAD, MEM_WORD, 32'd32, '0, 1'b0);
        issue(OP_LOAD, MEM_WORD, 32'd36, '0, 1'b0);

        // Valid every cycle and half the time on the previous address
        for (int i = 0; i < NUM_RANDOM; i++) begin
            r = rand_bits(1);
            if (r[0]) begin
                r     = rand_bits(6);
                addr6 = r[5:0];
            end
            r   = rand_bits(20);
            alu = {r[19:0], 6'd0, addr6};
            r   = rand_bits(3);
            t   = mem_mask_t'(3'(r % 5));
            r   = rand_bits(5);
            case (r[2:0])
                3'd0, 3'd1, 3'd2: issue(OP_STORE, t, alu, rand_bits(32), 1'b0);
                3'd3, 3'd4, 3'd5: issue(OP_LOAD, t, alu, '0, 1'b0);
                3'd6: issue(OP_ALU | {3'b000, r[4:3]}, t, alu, '0, 1'b0);
                default: issue(OP_STORE, t, alu, rand_bits(32), last_valid);
            endcase
        end

        repeat (3) issue(OP_IDLE, MEM_WORD, '0, '0, 1'b0);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("timeout: run did not finish within %0d ns", TIMEOUT_NS);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

/* verilog/byte_bank.sv */
`timescale 1ns/1ns
`include "mem_macros.svh"

module byte_bank (
    input  logic  clk,
    input  logic  reset,
    bank_if.bank  port
);

    localparam int DEPTH = 2 ** `MEM_BANK_AWIDTH;

    logic [7:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (port.we) begin
            mem[port.addr] <= port.wdata;
        end
    end

    // Registered read that holds the last byte between reads
    always_ff @(posedge clk) begin
        if (reset) begin
            port.rdata <= 8'h00;
        end else if (port.re) begin
            port.rdata <= mem[port.addr];
        end
    end

endmodule

/* verilog/ex_mem_latch.sv */
`timescale 1ns/1ns
`include "mem_macros.svh"

module ex_mem_latch import mem_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 valid,
    input  logic                 mem_read,
    input  logic                 mem_write,
    input  logic                 jal,
    input  logic                 lui,
    input  mem_mask_t            mem_type,
    input  logic [`MEM_XLEN-1:0] alu_out,
    input  logic [`MEM_XLEN-1:0] store_data,
    input  logic [`MEM_XLEN-1:0] imm,
    input  logic [`MEM_XLEN-1:0] pc_inc,
    input  logic                 wb_forward,
    input  logic [4:0]           rd,
    ex_mem_if.source             em
);

    // Control bits that decide whether memory is touched
    always_ff @(posedge clk) begin
        if (reset) begin
            em.valid     <= 1'b0;
            em.mem_read  <= 1'b0;
            em.mem_write <= 1'b0;
        end else begin
            em.valid     <= valid;
            em.mem_read  <= mem_read;
            em.mem_write <= mem_write;
        end
    end

    // Payload fields of the instruction
    always_ff @(posedge clk) begin
        em.jal        <= jal;
        em.lui        <= lui;
        em.mem_type   <= mem_type;
        em.alu_out    <= alu_out;
        em.store_data <= store_data;
        em.imm        <= imm;
        em.pc_inc     <= pc_inc;
        em.wb_forward <= wb_forward;
        em.rd         <= rd;
    end

endmodule

/* verilog/mem_access_stage.sv */
`timescale 1ns/1ns
`include "mem_macros.svh"

module mem_access_stage import mem_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    ex_mem_if.sink               em,
    input  logic [`MEM_XLEN-1:0] wb_result,
    bank_if.port                 lane0,
    bank_if.port                 lane1,
    bank_if.port                 lane2,
    bank_if.port                 lane3,
    mem_wb_if.source             mw
);

    logic [`MEM_XLEN-1:0]        write_data;
    logic [`MEM_XLEN-1:0]        store_lanes;
    logic [`MEM_XLEN-1:0]        reg_data;
    logic [1:0]                  byte_offset;
    logic [`MEM_BANK_AWIDTH-1:0] bank_addr;
    logic [`MEM_LANES-1:0]       lane_sel;
    logic [`MEM_LANES-1:0]       wr_lanes;
    logic [`MEM_LANES-1:0]       rd_lanes;
    logic                        store_type;

    // Forwarded writeback result replaces the store data
    assign write_data = em.wb_forward ? wb_result : em.store_data;

    assign byte_offset = em.alu_out[1:0];
    assign bank_addr   = em.alu_out[`MEM_BANK_ALO +: `MEM_BANK_AWIDTH];

    // Lanes covered by the access
    always_comb begin
        lane_sel = '0;
        case (em.mem_type)
            MEM_BYTE, MEM_UBYTE: lane_sel[byte_offset] = 1'b1;
            MEM_HALF, MEM_UHALF: lane_sel = byte_offset[1] ? 4'b1100 : 4'b0011;
            MEM_WORD:            lane_sel = 4'b1111;
            default:             lane_sel = '0;
        endcase
    end

    // Unsigned types are loads only
    assign store_type = (em.mem_type == MEM_BYTE) || (em.mem_type == MEM_HALF) ||
                        (em.mem_type == MEM_WORD);

    assign wr_lanes = lane_sel & {`MEM_LANES{em.valid & em.mem_write & store_type}};
    assign rd_lanes = lane_sel & {`MEM_LANES{em.valid & em.mem_read}};

    // Replicate the low bytes so each enabled lane sees its byte
    always_comb begin
        case (em.mem_type)
            MEM_BYTE: store_lanes = {4{write_data[7:0]}};
            MEM_HALF: store_lanes = {2{write_data[15:0]}};
            default:  store_lanes = write_data;
        endcase
    end

    assign lane0.addr  = bank_addr;
    assign lane0.re    = rd_lanes[0];
    assign lane0.we    = wr_lanes[0];
    assign lane0.wdata = store_lanes[7:0];

    assign lane1.addr  = bank_addr;
    assign lane1.re    = rd_lanes[1];
    assign lane1.we    = wr_lanes[1];
    assign lane1.wdata = store_lanes[15:8];

    assign lane2.addr  = bank_addr;
    assign lane2.re    = rd_lanes[2];
    assign lane2.we    = wr_lanes[2];
    assign lane2.wdata = store_lanes[23:16];

    assign lane3.addr  = bank_addr;
    assign lane3.re    = rd_lanes[3];
    assign lane3.we    = wr_lanes[3];
    assign lane3.wdata = store_lanes[31:24];

    // Link address wins over the upper immediate
    assign reg_data = em.jal ? em.pc_inc : (em.lui ? em.imm : em.alu_out);

    always_ff @(posedge clk) begin
        if (reset) begin
            mw.valid    <= 1'b0;
            mw.mem_read <= 1'b0;
        end else begin
            mw.valid    <= em.valid;
            mw.mem_read <= em.valid & em.mem_read;
        end
    end

    always_ff @(posedge clk) begin
        mw.mem_type    <= em.mem_type;
        mw.byte_offset <= byte_offset;
        mw.reg_data    <= reg_data;
        mw.rd          <= em.rd;
    end

endmodule

/* verilog/mem_pkg.sv */
`include "mem_macros.svh"

package mem_pkg;

    // Access width and extension of a load or store
    typedef enum logic [2:0] {
        MEM_BYTE  = 3'd0,
        MEM_HALF  = 3'd1,
        MEM_WORD  = 3'd2,
        MEM_UBYTE = 3'd3,
        MEM_UHALF = 3'd4
    } mem_mask_t;

    // Read bytes from all banks with lane 0 at the lowest address
    typedef logic [`MEM_LANES-1:0][7:0] lane_data_t;

endpackage

/* verilog/mem_stage_ifs.sv */
`timescale 1ns/1ns
`include "mem_macros.svh"

// Execute results held for the memory-access stage
interface ex_mem_if import mem_pkg::*; ();
    logic                 valid;
    logic                 mem_read;
    logic                 mem_write;
    logic                 jal;
    logic                 lui;
    mem_mask_t            mem_type;
    logic [`MEM_XLEN-1:0] alu_out;
    logic [`MEM_XLEN-1:0] store_data;
    logic [`MEM_XLEN-1:0] imm;
    logic [`MEM_XLEN-1:0] pc_inc;
    logic                 wb_forward;
    logic [4:0]           rd;

    modport source (output valid, mem_read, mem_write, jal, lui, mem_type,
                    output alu_out, store_data, imm, pc_inc, wb_forward, rd);
    modport sink (input valid, mem_read, mem_write, jal, lui, mem_type,
                  input alu_out, store_data, imm, pc_inc, wb_forward, rd);
endinterface

// Memory/writeback register contents
interface mem_wb_if import mem_pkg::*; ();
    logic                 valid;
    logic                 mem_read;
    mem_mask_t            mem_type;
    logic [1:0]           byte_offset;
    logic [`MEM_XLEN-1:0] reg_data;
    logic [4:0]           rd;

    modport source (output valid, mem_read, mem_type, byte_offset, reg_data, rd);
    modport sink (input valid, mem_read, mem_type, byte_offset, reg_data, rd);
endinterface

// One byte bank access port
interface bank_if;
    logic [`MEM_BANK_AWIDTH-1:0] addr;
    logic                        re;
    logic                        we;
    logic [7:0]                  wdata;
    logic [7:0]                  rdata;

    modport port (output addr, re, we, wdata, input rdata);
    modport bank (input addr, re, we, wdata, output rdata);
endinterface

/* verilog/mem_subsystem_top.sv */
`timescale 1ns/1ns
`include "mem_macros.svh"

module mem_subsystem_top import mem_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 valid,
    input  logic                 mem_read,
    input  logic                 mem_write,
    input  logic                 jal,
    input  logic                 lui,
    input  mem_mask_t            mem_type,
    input  logic [`MEM_XLEN-1:0] alu_out,
    input  logic [`MEM_XLEN-1:0] store_data,
    input  logic [`MEM_XLEN-1:0] imm,
    input  logic [`MEM_XLEN-1:0] pc_inc,
    input  logic                 wb_forward,
    input  logic [4:0]           rd,
    output logic                 wb_valid,
    output logic [4:0]           wb_rd,
    output logic [`MEM_XLEN-1:0] wb_result
);

    ex_mem_if em ();
    mem_wb_if mw ();
    bank_if   lane_bus [`MEM_LANES] ();

    lane_data_t lanes;

    ex_mem_latch i_ex_mem_latch (
        .clk(clk), .reset(reset), .valid(valid), .mem_read(mem_read),
        .mem_write(mem_write), .jal(jal), .lui(lui), .mem_type(mem_type),
        .alu_out(alu_out), .store_data(store_data), .imm(imm), .pc_inc(pc_inc),
        .wb_forward(wb_forward), .rd(rd), .em(em)
    );

    mem_access_stage i_mem_access_stage (
        .clk(clk), .reset(reset), .em(em), .wb_result(wb_result),
        .lane0(lane_bus[0]), .lane1(lane_bus[1]), .lane2(lane_bus[2]),
        .lane3(lane_bus[3]), .mw(mw)
    );

    // One bank per byte lane
    for (genvar i = 0; i < `MEM_LANES; i++) begin : g_bank
        byte_bank i_byte_bank (.clk(clk), .reset(reset), .port(lane_bus[i]));
        assign lanes[i] = lane_bus[i].rdata;
    end

    writeback_stage i_writeback_stage (
        .mw(mw), .lanes(lanes), .wb_valid(wb_valid), .wb_rd(wb_rd),
        .wb_result(wb_result)
    );

endmodule

/* verilog/writeback_stage.sv */
`timescale 1ns/1ns
`include "mem_macros.svh"

module writeback_stage import mem_pkg::*; (
    mem_wb_if.sink               mw,
    input  lane_data_t           lanes,
    output logic                 wb_valid,
    output logic [4:0]           wb_rd,
    output logic [`MEM_XLEN-1:0] wb_result
);

    logic [7:0]           sel_byte;
    logic [15:0]          sel_half;
    logic [`MEM_XLEN-1:0] load_value;

    // Bytes named by the address offset
    assign sel_byte = lanes[mw.byte_offset];
    assign sel_half = mw.byte_offset[1] ? {lanes[3], lanes[2]} : {lanes[1], lanes[0]};

    always_comb begin
        case (mw.mem_type)
            MEM_BYTE:  load_value = {{(`MEM_XLEN-8){sel_byte[7]}}, sel_byte};
            MEM_HALF:  load_value = {{(`MEM_XLEN-16){sel_half[15]}}, sel_half};
            MEM_UBYTE: load_value = {{(`MEM_XLEN-8){1'b0}}, sel_byte};
            MEM_UHALF: load_value = {{(`MEM_XLEN-16){1'b0}}, sel_half};
            MEM_WORD:  load_value = lanes;
            default:   load_value = '0;
        endcase
    end

    assign wb_result = mw.mem_read ? load_value : mw.reg_data;
    assign wb_valid  = mw.valid;
    assign wb_rd     = mw.rd;

endmodule
